// ==== src/aes_pkg.sv ====
/*
 * AES-128 shared definitions
 * Widths, request and status types, controller states, core latency,
 * forward S-box and round-constant tables and GF(2^8) helpers
 */

package aes_pkg;

    parameter int AES_BLOCK_BITS = 128;
    parameter int AES_NUM_ROUNDS = 10;
    parameter int AES_LATENCY    = 21;  // Whitening plus two clocks per round

    typedef logic [AES_BLOCK_BITS-1:0] aes_block_t;
    typedef logic [31:0]               aes_word_t;
    typedef logic [1:0]                agent_id_t;

    typedef struct packed {
        aes_block_t plaintext;
        aes_block_t key;
    } aes_req_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic done_latched;
    } aes_status_t;

    typedef enum logic [1:0] {
        IDLE,
        LAUNCH,
        WAIT_RESULT,
        DONE
    } ctrl_state_e;

    // ------------------------------
    // Forward S-box, entry 0x00 in the top byte
    localparam logic [2047:0] SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // Round constants for rounds 1 to 10
    localparam logic [79:0] RCON_TABLE = 80'h01_02_04_08_10_20_40_80_1b_36;

    // ------------------------------
    function automatic logic [7:0] sbox_lookup(input logic [7:0] b);
        return SBOX_TABLE[2047 - 8 * int'(b) -: 8];
    endfunction

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] gf_xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] round_rcon(input int idx);
        return RCON_TABLE[79 - 8 * (idx - 1) -: 8];
    endfunction

endpackage

// ==== src/aes_key_expand.sv ====
/*
 * AES-128 key schedule stage
 * Derives the next round key over two clocks, in step with its round
 */
`timescale 1ns/10ps

module aes_key_expand
    import aes_pkg::*;
#(
    parameter int ROUND_IDX = 1
) (
    input  logic       clk,
    input  logic       arst_n,
    input  aes_block_t key_in,
    output aes_block_t key_next,
    output aes_block_t round_key
);

    aes_word_t w0, w1, w2, w3;
    aes_word_t v0, v1, v2, v3;
    aes_word_t rot_w;
    aes_block_t v_q;
    aes_word_t sub_q;

    assign {w0, w1, w2, w3} = key_in;

    // XOR chain with the round constant folded into the first word
    assign v0 = w0 ^ {round_rcon(ROUND_IDX), 24'h0};
    assign v1 = v0 ^ w1;
    assign v2 = v1 ^ w2;
    assign v3 = v2 ^ w3;
    assign rot_w = {w3[23:0], w3[31:24]};   // RotWord

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v_q   <= '0;
            sub_q <= '0;
            key_next <= '0;
        end else begin
            v_q   <= {v0, v1, v2, v3};
            sub_q <= {sbox_lookup(rot_w[31:24]), sbox_lookup(rot_w[23:16]),
                      sbox_lookup(rot_w[15:8]), sbox_lookup(rot_w[7:0])};
            key_next <= round_key;
        end
    end

    // Key for the matching round, used at its second stage
    assign round_key = v_q ^ {4{sub_q}};

endmodule

// ==== src/aes_round.sv ====
/*
 * AES cipher round
 * Stage one substitutes all bytes, stage two shifts rows, mixes
 * columns (not in the final round) and adds the round key
 */
`timescale 1ns/10ps

module aes_round
    import aes_pkg::*;
#(
    parameter bit FINAL = 1'b0
) (
    input  logic       clk,
    input  logic       arst_n,
    input  aes_block_t state_in,
    input  aes_block_t round_key,
    output aes_block_t state_out
);

    logic [7:0] sb_q [16];  // Byte i sits at bits 127-8i
    logic [7:0] sr [16];
    aes_block_t mixed;

    // ------------------------------
    // SubBytes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                sb_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 16; i++) begin
                sb_q[i] <= sbox_lookup(state_in[127 - 8*i -: 8]);
            end
        end
    end

    // ------------------------------
    // ShiftRows then MixColumns
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                sr[4*c + r] = sb_q[4*((c + r) % 4) + r];
            end
        end
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                if (FINAL) begin
                    mixed[127 - 8*(4*c + r) -: 8] = sr[4*c + r];
                end else begin
                    // 2a0 ^ 3a1 ^ a2 ^ a3, rotated per row
                    mixed[127 - 8*(4*c + r) -: 8] = gf_xtime(sr[4*c + r])
                        ^ gf_xtime(sr[4*c + (r + 1) % 4]) ^ sr[4*c + (r + 1) % 4]
                        ^ sr[4*c + (r + 2) % 4] ^ sr[4*c + (r + 3) % 4];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_out <= '0;
        end else begin
            state_out <= mixed ^ round_key;   // AddRoundKey
        end
    end

endmodule

// ==== src/aes_core.sv ====
/*
 * AES-128 encryption pipeline
 * Whitening register followed by ten two-clock rounds with their key stages
 */
`timescale 1ns/10ps

module aes_core
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  aes_req_t   operand,
    output aes_block_t result
);

    aes_block_t white_state_q;
    aes_block_t white_key_q;
    aes_block_t state_chain [AES_NUM_ROUNDS + 1];
    aes_block_t key_chain [AES_NUM_ROUNDS];
    aes_block_t round_key [AES_NUM_ROUNDS];

    // Initial AddRoundKey with the cipher key
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            white_state_q <= '0;
            white_key_q   <= '0;
        end else begin
            white_state_q <= operand.plaintext ^ operand.key;
            white_key_q   <= operand.key;
        end
    end

    assign state_chain[0] = white_state_q;
    assign key_chain[0]   = white_key_q;

    for (genvar i = 0; i < AES_NUM_ROUNDS; i++) begin : g_stage
        aes_round #(.FINAL(i == AES_NUM_ROUNDS - 1)) round_inst (
            .clk       (clk),
            .arst_n    (arst_n),
            .state_in  (state_chain[i]),
            .round_key (round_key[i]),
            .state_out (state_chain[i + 1])
        );

        if (i < AES_NUM_ROUNDS - 1) begin : g_key
            aes_key_expand #(.ROUND_IDX(i + 1)) key_inst (
                .clk       (clk),
                .arst_n    (arst_n),
                .key_in    (key_chain[i]),
                .key_next  (key_chain[i + 1]),
                .round_key (round_key[i])
            );
        end else begin : g_key_last
            aes_key_expand #(.ROUND_IDX(i + 1)) key_inst (
                .clk       (clk),
                .arst_n    (arst_n),
                .key_in    (key_chain[i]),
                .key_next  (),  // No stage follows the last round
                .round_key (round_key[i])
            );
        end
    end

    assign result = state_chain[AES_NUM_ROUNDS];

endmodule

// ==== src/aes_access_ctrl.sv ====
/*
 * Access-controlled request FSM
 * Accepts a start only from agents allowed by the policy, holds the
 * operand for the core, waits the pipeline latency and captures the result
 */
`timescale 1ns/10ps

module aes_access_ctrl
    import aes_pkg::*;
#(
    parameter logic [(1 << $bits(agent_id_t)) - 1:0] ACCESS_POLICY = 4'b0010
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start,
    input  agent_id_t   agent,
    input  aes_req_t    req,
    output aes_req_t    operand,
    input  aes_block_t  result,
    output aes_block_t  ciphertext,
    output aes_status_t status
);

    localparam int CNT_BITS = $clog2(AES_LATENCY);

    ctrl_state_e state;
    logic [CNT_BITS-1:0] lat_cnt;
    logic accept;

    // Policy bit indexed by the requesting agent
    assign accept = (state == IDLE) && start && ACCESS_POLICY[agent];

    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            lat_cnt    <= '0;
            ciphertext <= '0;
            status     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    status.done <= 1'b0;   // One-clock done pulse
                    if (accept) begin
                        state <= LAUNCH;
                    end
                end
                LAUNCH: begin
                    status.busy         <= 1'b1;
                    status.done_latched <= 1'b0;
                    lat_cnt             <= '0;
                    state               <= WAIT_RESULT;
                end
                WAIT_RESULT: begin
                    if (lat_cnt == CNT_BITS'(AES_LATENCY - 1)) begin
                        state <= DONE;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                DONE: begin
                    ciphertext <= result;
                    status     <= '{busy: 1'b0, done: 1'b1, done_latched: 1'b1};
                    state      <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Operand stays put while the core works on it
    always_ff @(posedge clk) begin
        if (accept) begin
            operand <= req;
        end
    end

endmodule

// ==== src/secure_aes_top.sv ====
/*
 * Secure AES-128 top level
 * Request controller with access policy in front of the pipelined core
 */
`timescale 1ns/10ps

module secure_aes_top
    import aes_pkg::*;
#(
    parameter logic [(1 << $bits(agent_id_t)) - 1:0] ACCESS_POLICY = 4'b0010
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start,
    input  agent_id_t   agent,
    input  aes_req_t    req,
    output aes_block_t  ciphertext,
    output aes_status_t status
);

    aes_req_t   operand;
    aes_block_t result;

    aes_access_ctrl #(.ACCESS_POLICY(ACCESS_POLICY)) aes_access_ctrl_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .agent      (agent),
        .req        (req),
        .operand    (operand),
        .result     (result),
        .ciphertext (ciphertext),
        .status     (status)
    );

    aes_core aes_core_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .operand (operand),
        .result  (result)
    );

endmodule

// ==== tests/aes_ctrl_assertions.sv ====
/*
 * Controller status properties
 * One-clock done pulse, busy and done exclusive, done_latched set with done
 */
`timescale 1ns/10ps

module aes_ctrl_assertions
    import aes_pkg::*;
(
    input logic        clk,
    input logic        arst_n,
    input aes_status_t status
);

    done_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        status.done |=> !status.done)
        else $error("done stayed high for two consecutive cycles");

    busy_done_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(status.busy && status.done))
        else $error("busy and done high together");

    latched_with_done: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(status.done_latched) |-> status.done)
        else $error("done_latched rose without done");

endmodule

// ==== include/aes_ref.svh ====
/*
 * AES-128 reference model
 * Plain behavioral encryption, S-box derived from the GF(2^8) inverse
 * and the affine map rather than a table
 */
`ifndef AES_REF_SVH
`define AES_REF_SVH

function automatic logic [7:0] ref_gmul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            p ^= x;
        end
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

// Inverse as x^254, zero maps to zero
function automatic logic [7:0] ref_sbox(input logic [7:0] x);
    logic [7:0] sq;
    logic [7:0] inv;
    sq  = x;
    inv = 8'h01;
    for (int i = 1; i < 8; i++) begin
        sq  = ref_gmul(sq, sq);
        inv = ref_gmul(inv, sq);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
        ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

function automatic logic [127:0] aes128_ref(input logic [127:0] pt, input logic [127:0] key);
    logic [127:0] st;
    logic [127:0] rk;
    logic [127:0] nx;
    logic [31:0]  t;
    logic [7:0]   rcon;
    logic [7:0]   a [4];
    st   = pt ^ key;
    rk   = key;
    rcon = 8'h01;
    for (int rnd = 1; rnd <= 10; rnd++) begin
        t = {ref_sbox(rk[23:16]), ref_sbox(rk[15:8]), ref_sbox(rk[7:0]), ref_sbox(rk[31:24])};
        t[31:24] ^= rcon;
        rk[127:96] ^= t;
        rk[95:64]  ^= rk[127:96];
        rk[63:32]  ^= rk[95:64];
        rk[31:0]   ^= rk[63:32];
        rcon = ref_gmul(rcon, 8'h02);
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                nx[127 - 8*(4*c + r) -: 8] = ref_sbox(st[127 - 8*(4*((c + r) % 4) + r) -: 8]);
            end
        end
        if (rnd < 10) begin
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    a[r] = nx[127 - 8*(4*c + r) -: 8];
                end
                for (int r = 0; r < 4; r++) begin
                    nx[127 - 8*(4*c + r) -: 8] = ref_gmul(a[r], 8'h02)
                        ^ ref_gmul(a[(r + 1) % 4], 8'h03) ^ a[(r + 2) % 4] ^ a[(r + 3) % 4];
                end
            end
        end
        st = nx ^ rk;
    end
    return st;
endfunction

`endif

// ==== tests/tb_secure_aes.sv ====
/*
 * Testbench for the secure AES-128 top level
 * Known-answer and random encryptions from the allowed agent, denied
 * agents, done_latched behavior and a start issued while busy
 */
`timescale 1ns/10ps

module tb_secure_aes
    import aes_pkg::*;
();

    `include "aes_ref.svh"

    localparam logic [15:0] LFSR_SEED      = 16'd91;
    localparam int          TIMEOUT_CYCLES = 100;
    localparam aes_block_t  FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam aes_block_t  FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_block_t  FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic        clk;
    logic        arst_n;
    logic        start;
    agent_id_t   agent;
    aes_req_t    req;
    aes_block_t  ciphertext;
    aes_status_t status;

    aes_block_t  exp_q[$];      // Expected results, oldest first
    int          done_count = 0;
    int          sent_count = 0;
    logic [15:0] lfsr_state = LFSR_SEED;

    secure_aes_top secure_aes_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .agent      (agent),
        .req        (req),
        .ciphertext (ciphertext),
        .status     (status)
    );

    bind aes_access_ctrl aes_ctrl_assertions aes_ctrl_assertions_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .status (status)
    );

    always #4 clk = ~clk;

    // ------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_block(input string name, input aes_block_t got, input aes_block_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_status(input string name, input aes_status_t got,
                                input aes_status_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_block(output aes_block_t value);
        value = '0;
        for (int i = 0; i < AES_BLOCK_BITS; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[AES_BLOCK_BITS-2:0], lfsr_state[0]};
        end
    endtask

    // ------------------------------
    // Compare each done pulse against the oldest expected result
    always @(negedge clk) begin
        if (arst_n && status.done) begin
            if (exp_q.size() == 0) begin
                report_failure("done pulse seen with no request outstanding");
            end
            check_block("ciphertext", ciphertext, exp_q.pop_front());
            done_count++;
        end
    end

    task automatic issue_start(input agent_id_t id, input aes_req_t r);
        @(posedge clk);
        start <= 1'b1;
        agent <= id;
        req   <= r;
        @(posedge clk);         // Acceptance edge
        start <= 1'b0;
    endtask

    task automatic idle_window(input int n, input aes_status_t exp_status,
                               input aes_block_t exp_ct);
        repeat (n) begin
            @(negedge clk);
            check_status("status", status, exp_status);
            check_block("ciphertext", ciphertext, exp_ct);
        end
    endtask

    task automatic encrypt(input aes_block_t pt, input aes_block_t key,
                           input aes_block_t expected, input bit interfere);
        bit          latched_exp;
        aes_req_t    noise;
        int          cycles;
        int          count_before;
        @(negedge clk);
        latched_exp  = (sent_count > 0);    // Set by any earlier completion
        count_before = done_count;
        exp_q.push_back(expected);
        sent_count++;
        issue_start(2'd1, '{plaintext: pt, key: key});
        if (interfere) begin
            // Held into LAUNCH with new data, the operand must not change
            draw_block(noise.plaintext);
            draw_block(noise.key);
            start <= 1'b1;
            req   <= noise;
        end
        @(negedge clk);
        check_status("status after accept", status,
                     '{busy: 1'b0, done: 1'b0, done_latched: latched_exp});
        cycles = 0;
        while (!status.done && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
            if (interfere && cycles == 4) begin
                draw_block(noise.plaintext);
                draw_block(noise.key);
                start <= 1'b1;      // Should be ignored while busy
                req   <= noise;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            if (cycles == 1) begin
                check_status("status after launch", status,
                             '{busy: 1'b1, done: 1'b0, done_latched: 1'b0});
            end
        end
        if (!status.done) begin
            report_failure("Timed out waiting for done after an accepted start");
        end
        check_status("status at done", status, '{busy: 1'b0, done: 1'b1, done_latched: 1'b1});
        check_count("done latency", cycles, AES_LATENCY + 2);
        @(negedge clk);
        check_count("done pulses", done_count, count_before + 1);
        check_status("status after done", status,
                     '{busy: 1'b0, done: 1'b0, done_latched: 1'b1});
    endtask

    // ------------------------------
    initial begin
        aes_block_t  pt;
        aes_block_t  key;
        aes_req_t    noise;
        aes_block_t  last_ct;
        agent_id_t   denied [3] = '{2'd0, 2'd2, 2'd3};
        clk    = 1'b0;
        arst_n = 1'b0;
        start  = 1'b0;
        agent  = '0;
        req    = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        @(negedge clk);
        check_status("status after reset", status, '0);
        check_block("ciphertext after reset", ciphertext, '0);

        // Known-answer vector
        check_block("aes128_ref", aes128_ref(FIPS_PT, FIPS_KEY), FIPS_CT);
        encrypt(FIPS_PT, FIPS_KEY, FIPS_CT, 1'b0);

        for (int i = 0; i < 8; i++) begin
            draw_block(pt);
            draw_block(key);
            encrypt(pt, key, aes128_ref(pt, key), 1'b0);
        end

        // Agents outside the policy
        last_ct = aes128_ref(pt, key);
        foreach (denied[i]) begin
            draw_block(noise.plaintext);
            draw_block(noise.key);
            issue_start(denied[i], noise);
            idle_window(40, '{busy: 1'b0, done: 1'b0, done_latched: 1'b1}, last_ct);
        end

        // done_latched is high here and clears one clock after the next accept
        draw_block(pt);
        draw_block(key);
        check_status("status before busy test", status,
                     '{busy: 1'b0, done: 1'b0, done_latched: 1'b1});
        encrypt(pt, key, aes128_ref(pt, key), 1'b1);
        idle_window(30, '{busy: 1'b0, done: 1'b0, done_latched: 1'b1}, aes128_ref(pt, key));

        if (exp_q.size() == 0 && done_count == sent_count) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure("Number of done pulses does not match the accepted requests");
        end
    end

endmodule

// ==== compile.f ====
+incdir+include
src/aes_pkg.sv
src/aes_key_expand.sv
src/aes_round.sv
src/aes_core.sv
src/aes_access_ctrl.sv
src/secure_aes_top.sv
tests/aes_ctrl_assertions.sv
tests/tb_secure_aes.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_secure_aes

out=$(./obj_dir/Vtb_secure_aes 2>&1 || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi
